/* soqpsk_defs.svh */
// Widths, trace-back depth and APB register offsets for the SOQPSK trellis decoder
`ifndef SOQPSK_DEFS_SVH
`define SOQPSK_DEFS_SVH

// Matched-filter rotation width, also the phase error width
`define ROT_BITS 10

// Leading rotation bits used as branch metric
`define METRIC_SIZE 8

// Accumulated metric, signed, with headroom
`define METRIC_BITS (`METRIC_SIZE + 4)

// Survivor vectors held by the trace-back
`define TRACE_DEPTH 16

// APB byte offsets
`define REG_CTRL     4'h0
`define REG_DECAY    4'h4
`define REG_SYMCOUNT 4'h8

`endif

/* soqpskPkg.sv */
// Metric, state and survivor types plus the trellis partner function
`default_nettype none
`include "soqpsk_defs.svh"

package soqpskPkg;

   // Signed accumulated path metric
   typedef logic signed [`METRIC_BITS-1:0] metric_t;

   // One of the four trellis states
   typedef logic [1:0] stateIdx_t;

   // One survivor bit per state
   // 1 = zero branch from same state, 0 = rotating branch from partner
   typedef logic [3:0] selVec_t;

   // --------------------
   // Rotating-branch predecessor of a state
   // Even symbols pair 0/2 and 1/3, odd symbols pair 0/1 and 2/3
   function automatic stateIdx_t partnerState(input stateIdx_t state, input logic even);
      stateIdx_t partner;
      if (even) begin
         partner = state ^ 2'd2;
      end else begin
         partner = state ^ 2'd1;
      end
      return partner;
   endfunction

endpackage

`default_nettype wire

/* soqpskAcs.sv */
// Add-compare-select unit with leaky metric, normalization and winning imaginary output
`timescale 1ns/1ps
`default_nettype none
`include "soqpsk_defs.svh"

module soqpskAcs import soqpskPkg::*; (
   input  wire logic                 clk,
   input  wire logic                 reset,
   input  wire logic                 symEn,
   input  wire logic                 clear,
   input  wire logic [7:0]           decayFactor,
   input  wire logic [`ROT_BITS-1:0] zeroReal,
   input  wire logic [`ROT_BITS-1:0] rotReal,
   input  wire logic [`ROT_BITS-1:0] zeroImag,
   input  wire logic [`ROT_BITS-1:0] rotImag,
   input  wire metric_t              ownMetric,
   input  wire metric_t              partnerMetric,
   input  wire logic                 normalizeIn,
   output metric_t                   metric,
   output logic                      sel,
   output logic                      normalizeOut,
   output logic [`ROT_BITS-1:0]      branchImag
);

   // Quarter of the full signed metric range
   localparam int QUARTER = 1 << (`METRIC_BITS - 2);
   // Two guard bits for the sums
   localparam int WIDE = `METRIC_BITS + 2;

   logic signed [`METRIC_SIZE-1:0] zeroBranch;
   logic signed [`METRIC_SIZE-1:0] rotBranch;
   logic signed [`METRIC_BITS+8:0] zeroScaled;
   logic signed [`METRIC_BITS+8:0] rotScaled;
   logic signed [WIDE-1:0]         zeroSum;
   logic signed [WIDE-1:0]         rotSum;
   logic signed [WIDE-1:0]         bestSum;
   logic signed [WIDE-1:0]         adjusted;
   logic                           zeroWins;

   // Branch metrics from the top bits of the real rotations
   assign zeroBranch = zeroReal[`ROT_BITS-1 -: `METRIC_SIZE];
   assign rotBranch  = rotReal[`ROT_BITS-1 -: `METRIC_SIZE];

   // --------------------
   // Leak of decayFactor/256 on each predecessor
   assign zeroScaled = ownMetric * $signed({1'b0, decayFactor});
   assign rotScaled  = partnerMetric * $signed({1'b0, decayFactor});

   assign zeroSum = WIDE'(zeroScaled >>> 8) + WIDE'(zeroBranch);
   assign rotSum  = WIDE'(rotScaled >>> 8) + WIDE'(rotBranch);

   // Compare and select, a tie keeps the zero branch
   assign zeroWins = zeroSum >= rotSum;
   assign bestSum  = zeroWins ? zeroSum : rotSum;

   // All four units drop a quarter range together
   assign adjusted = normalizeIn ? bestSum - WIDE'(QUARTER) : bestSum;

   // --------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         metric     <= '0;
         sel        <= 1'b1;
         branchImag <= '0;
      end else if (clear) begin
         metric <= '0;
      end else if (symEn) begin
         metric     <= metric_t'(adjusted);
         sel        <= zeroWins;
         branchImag <= zeroWins ? zeroImag : rotImag;
      end
   end

   // Flag for the shared normalization
   assign normalizeOut = metric > metric_t'(QUARTER);

endmodule

`default_nettype wire

/* maxMetric4.sv */
// Registered four-way signed compare returning the best trellis state
`timescale 1ns/1ps
`default_nettype none

module maxMetric4 import soqpskPkg::*; (
   input  wire logic    clk,
   input  wire logic    reset,
   input  wire metric_t a,
   input  wire metric_t b,
   input  wire metric_t c,
   input  wire metric_t d,
   output stateIdx_t    index
);

   metric_t   bestAB;
   metric_t   bestCD;
   stateIdx_t idxAB;
   stateIdx_t idxCD;

   // First round in two pairs, lower index wins a tie
   always_comb begin
      if (b > a) begin
         bestAB = b;
         idxAB  = 2'd1;
      end else begin
         bestAB = a;
         idxAB  = 2'd0;
      end
      if (d > c) begin
         bestCD = d;
         idxCD  = 2'd3;
      end else begin
         bestCD = c;
         idxCD  = 2'd2;
      end
   end

   // Final round, registered
   always_ff @(posedge clk) begin
      if (reset) begin
         index <= '0;
      end else begin
         index <= (bestCD > bestAB) ? idxCD : idxAB;
      end
   end

endmodule

`default_nettype wire

/* traceBackSoqpsk.sv */
// Survivor history and trace-back producing one hard bit per symbol
`timescale 1ns/1ps
`default_nettype none
`include "soqpsk_defs.svh"

module traceBackSoqpsk import soqpskPkg::*; (
   input  wire logic      clk,
   input  wire logic      reset,
   input  wire logic      symEn,
   input  wire logic      symEnEven,
   input  wire selVec_t   sel,
   input  wire stateIdx_t index,
   output logic           decision
);

   localparam int DEPTH = `TRACE_DEPTH;

   // History, entry 0 is the newest
   selVec_t          selHist [DEPTH];
   logic [DEPTH-1:0] evenHist;
   logic             oldestBit;

   // --------------------
   // Walk back from the best state
   // Incoming vector first, then the stored ones
   always_comb begin : walk
      stateIdx_t state;
      state = index;
      if (!sel[state]) begin
         state = partnerState(state, symEnEven);
      end
      for (int i = 0; i < DEPTH - 1; i++) begin
         if (!selHist[i][state]) begin
            state = partnerState(state, evenHist[i]);
         end
      end
      // Survivor bit of the oldest symbol on the path
      oldestBit = selHist[DEPTH-1][state];
   end

   // --------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < DEPTH; i++) begin
            selHist[i] <= '1;
         end
         evenHist <= '0;
         decision <= 1'b0;
      end else if (symEn) begin
         selHist[0] <= sel;
         for (int i = 1; i < DEPTH; i++) begin
            selHist[i] <= selHist[i-1];
         end
         evenHist <= {evenHist[DEPTH-2:0], symEnEven};
         // 1 when the rotating branch survived
         decision <= ~oldestBit;
      end
   end

endmodule

`default_nettype wire

/* viterbiRegs.sv */
// APB register block holding decay factor, metric clear and symbol count
`timescale 1ns/1ps
`default_nettype none
`include "soqpsk_defs.svh"

module viterbiRegs (
   input  wire logic        clk,
   input  wire logic        reset,
   input  wire logic        symEn,
   input  wire logic        pSel,
   input  wire logic        pEnable,
   input  wire logic        pWrite,
   input  wire logic [3:0]  pAddr,
   input  wire logic [31:0] pWData,
   output logic [31:0]      pRData,
   output logic             pReady,
   output logic             pSlvErr,
   output logic [7:0]       decayFactor,
   output logic             metricClear
);

   logic        access;
   logic        addrHit;
   logic        writeAccess;
   logic [31:0] symCount;

   // Access phase of a transfer, never stalled
   assign access      = pSel & pEnable;
   assign writeAccess = access & pWrite & addrHit;
   assign addrHit     = (pAddr == `REG_CTRL) || (pAddr == `REG_DECAY)
                        || (pAddr == `REG_SYMCOUNT);

   assign pReady  = 1'b1;
   assign pSlvErr = access & ~addrHit;

   // --------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         decayFactor <= 8'd255;
         metricClear <= 1'b0;
      end else begin
         // Single cycle clear strobe
         metricClear <= writeAccess & (pAddr == `REG_CTRL) & pWData[0];
         if (writeAccess && pAddr == `REG_DECAY) begin
            decayFactor <= pWData[7:0];
         end
      end
   end

   // Symbols seen since reset or last clear
   always_ff @(posedge clk) begin
      if (reset || metricClear) begin
         symCount <= '0;
      end else if (symEn) begin
         symCount <= symCount + 32'd1;
      end
   end

   // --------------------
   // Read mux, CTRL always reads 0
   always_comb begin
      case (pAddr)
         `REG_DECAY:    pRData = {24'd0, decayFactor};
         `REG_SYMCOUNT: pRData = symCount;
         default:       pRData = '0;
      endcase
   end

endmodule

`default_nettype wire

/* soqpskViterbi.sv */
// SOQPSK trellis decoder top with input muxes, ACS array, best state, phase error and trace-back
`timescale 1ns/1ps
`default_nettype none
`include "soqpsk_defs.svh"

module soqpskViterbi import soqpskPkg::*; (
   input  wire logic                 clk,
   input  wire logic                 reset,
   input  wire logic                 symEn,
   input  wire logic [`ROT_BITS-1:0] mfZr0Real,
   input  wire logic [`ROT_BITS-1:0] mfPr0Real,
   input  wire logic [`ROT_BITS-1:0] mfMr0Real,
   input  wire logic [`ROT_BITS-1:0] mfZr1Real,
   input  wire logic [`ROT_BITS-1:0] mfPr1Real,
   input  wire logic [`ROT_BITS-1:0] mfMr1Real,
   input  wire logic [`ROT_BITS-1:0] mfZr2Real,
   input  wire logic [`ROT_BITS-1:0] mfPr2Real,
   input  wire logic [`ROT_BITS-1:0] mfMr2Real,
   input  wire logic [`ROT_BITS-1:0] mfZr3Real,
   input  wire logic [`ROT_BITS-1:0] mfPr3Real,
   input  wire logic [`ROT_BITS-1:0] mfMr3Real,
   input  wire logic [`ROT_BITS-1:0] mfZr0Imag,
   input  wire logic [`ROT_BITS-1:0] mfPr0Imag,
   input  wire logic [`ROT_BITS-1:0] mfMr0Imag,
   input  wire logic [`ROT_BITS-1:0] mfZr1Imag,
   input  wire logic [`ROT_BITS-1:0] mfPr1Imag,
   input  wire logic [`ROT_BITS-1:0] mfMr1Imag,
   input  wire logic [`ROT_BITS-1:0] mfZr2Imag,
   input  wire logic [`ROT_BITS-1:0] mfPr2Imag,
   input  wire logic [`ROT_BITS-1:0] mfMr2Imag,
   input  wire logic [`ROT_BITS-1:0] mfZr3Imag,
   input  wire logic [`ROT_BITS-1:0] mfPr3Imag,
   input  wire logic [`ROT_BITS-1:0] mfMr3Imag,
   input  wire logic                 pSel,
   input  wire logic                 pEnable,
   input  wire logic                 pWrite,
   input  wire logic [3:0]           pAddr,
   input  wire logic [31:0]          pWData,
   output logic [31:0]               pRData,
   output logic                      pReady,
   output logic                      pSlvErr,
   output stateIdx_t                 index,
   output logic                      decision,
   output logic [`ROT_BITS-1:0]      phaseError
);

   logic [`ROT_BITS-1:0] zrReal [4];
   logic [`ROT_BITS-1:0] prReal [4];
   logic [`ROT_BITS-1:0] mrReal [4];
   logic [`ROT_BITS-1:0] zrImag [4];
   logic [`ROT_BITS-1:0] prImag [4];
   logic [`ROT_BITS-1:0] mrImag [4];
   logic [`ROT_BITS-1:0] zeroRealQ [4];
   logic [`ROT_BITS-1:0] zeroImagQ [4];
   logic [`ROT_BITS-1:0] rotRealQ [4];
   logic [`ROT_BITS-1:0] rotImagQ [4];
   logic [`ROT_BITS-1:0] branchImag [4];
   logic [`ROT_BITS-1:0] imagDly [4];
   metric_t              metric [4];
   metric_t              partnerMetric [4];
   logic [3:0]           normFlag;
   logic                 normalizeAll;
   selVec_t              selNow;
   selVec_t              selDly;
   stateIdx_t            bestIdx;
   logic                 symEnEven;
   logic                 nextEven;
   logic [7:0]           decayFactor;
   logic                 metricClear;

   assign zrReal = '{mfZr0Real, mfZr1Real, mfZr2Real, mfZr3Real};
   assign prReal = '{mfPr0Real, mfPr1Real, mfPr2Real, mfPr3Real};
   assign mrReal = '{mfMr0Real, mfMr1Real, mfMr2Real, mfMr3Real};
   assign zrImag = '{mfZr0Imag, mfZr1Imag, mfZr2Imag, mfZr3Imag};
   assign prImag = '{mfPr0Imag, mfPr1Imag, mfPr2Imag, mfPr3Imag};
   assign mrImag = '{mfMr0Imag, mfMr1Imag, mfMr2Imag, mfMr3Imag};

   viterbiRegs regs (
      .clk(clk), .reset(reset), .symEn(symEn),
      .pSel(pSel), .pEnable(pEnable), .pWrite(pWrite), .pAddr(pAddr), .pWData(pWData),
      .pRData(pRData), .pReady(pReady), .pSlvErr(pSlvErr),
      .decayFactor(decayFactor), .metricClear(metricClear)
   );

   // Parity of the symbol the ACS array updates on this symEn
   always_ff @(posedge clk) begin
      if (reset) begin
         symEnEven <= 1'b1;
      end else if (symEn) begin
         symEnEven <= ~symEnEven;
      end
   end

   // --------------------
   // Input capture, parity is that of the following update
   // Even uses Pr of the partner, odd uses Mr
   assign nextEven = ~symEnEven;

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int s = 0; s < 4; s++) begin
            zeroRealQ[s] <= '0;
            zeroImagQ[s] <= '0;
            rotRealQ[s]  <= '0;
            rotImagQ[s]  <= '0;
         end
      end else if (symEn) begin
         for (int s = 0; s < 4; s++) begin
            zeroRealQ[s] <= zrReal[s];
            zeroImagQ[s] <= zrImag[s];
            rotRealQ[s]  <= nextEven ? prReal[partnerState(stateIdx_t'(s), 1'b1)]
                                     : mrReal[partnerState(stateIdx_t'(s), 1'b0)];
            rotImagQ[s]  <= nextEven ? prImag[partnerState(stateIdx_t'(s), 1'b1)]
                                     : mrImag[partnerState(stateIdx_t'(s), 1'b0)];
         end
      end
   end

   // Partner metric for the current parity
   always_comb begin
      for (int s = 0; s < 4; s++) begin
         partnerMetric[s] = metric[partnerState(stateIdx_t'(s), symEnEven)];
      end
   end

   assign normalizeAll = |normFlag;

   // --------------------
   for (genvar s = 0; s < 4; s++) begin : gAcs
      soqpskAcs acs (
         .clk(clk), .reset(reset), .symEn(symEn), .clear(metricClear),
         .decayFactor(decayFactor),
         .zeroReal(zeroRealQ[s]), .rotReal(rotRealQ[s]),
         .zeroImag(zeroImagQ[s]), .rotImag(rotImagQ[s]),
         .ownMetric(metric[s]), .partnerMetric(partnerMetric[s]),
         .normalizeIn(normalizeAll), .metric(metric[s]), .sel(selNow[s]),
         .normalizeOut(normFlag[s]), .branchImag(branchImag[s])
      );
   end

   maxMetric4 best (
      .clk(clk), .reset(reset),
      .a(metric[0]), .b(metric[1]), .c(metric[2]), .d(metric[3]),
      .index(bestIdx)
   );

   // Align best state, survivors and imaginary parts to the symbol
   always_ff @(posedge clk) begin
      if (reset) begin
         index  <= '0;
         selDly <= '1;
         for (int s = 0; s < 4; s++) begin
            imagDly[s] <= '0;
         end
      end else if (symEn) begin
         index  <= bestIdx;
         selDly <= selNow;
         for (int s = 0; s < 4; s++) begin
            imagDly[s] <= branchImag[s];
         end
      end
   end

   // Phase error from the branch the best state chose
   always_ff @(posedge clk) begin
      if (reset) begin
         phaseError <= '0;
      end else if (symEn) begin
         phaseError <= imagDly[index];
      end
   end

   traceBackSoqpsk traceBack (
      .clk(clk), .reset(reset), .symEn(symEn), .symEnEven(symEnEven),
      .sel(selDly), .index(index), .decision(decision)
   );

endmodule

`default_nettype wire

/* soqpskViterbi_checker.sv */
// Bound assertions on the APB handshake, the metric clear strobe and symEn spacing
`timescale 1ns/1ps
`default_nettype none

module soqpskViterbiChecker (
   input wire logic clk,
   input wire logic reset,
   input wire logic symEn,
   input wire logic pSel,
   input wire logic pEnable,
   input wire logic metricClear
);

   // Access cycle only after a setup cycle with pSel high
   apbSetupFirst: assert property (@(posedge clk) disable iff (reset)
      $rose(pEnable) |-> $past(pSel) && pSel)
      else $error("pEnable rose without a preceding APB setup cycle");

   apbEnableInSel: assert property (@(posedge clk) disable iff (reset)
      pEnable |-> pSel)
      else $error("pEnable high while pSel is low");

   // --------------------
   // Clear is a single cycle strobe
   clearOneCycle: assert property (@(posedge clk) disable iff (reset)
      metricClear |=> !metricClear)
      else $error("metricClear stayed high for more than one cycle");

   // No back to back symbol strobes
   symEnSpaced: assert property (@(posedge clk) disable iff (reset)
      symEn |=> !symEn)
      else $error("symEn pulsed on two adjacent cycles");

endmodule

bind soqpskViterbi soqpskViterbiChecker protocolCheck (
   .clk(clk), .reset(reset), .symEn(symEn),
   .pSel(pSel), .pEnable(pEnable), .metricClear(metricClear)
);

`default_nettype wire

/* soqpskViterbiTb.sv */
// Testbench for the SOQPSK trellis decoder with APB tasks, path stimulus and output checks
`timescale 1ns/1ps
`default_nettype none
`include "soqpsk_defs.svh"

module soqpskViterbiTb import soqpskPkg::*; ();

   localparam int ROT_W        = `ROT_BITS;
   localparam int CLK_PERIOD   = 100;
   localparam int SYM_PERIOD   = 4;
   localparam int RESET_CYCLES = 16;
   localparam int LAT_IDX      = 2;
   localparam int LAT_PHASE    = 3;
   localparam int LAT_DEC      = `TRACE_DEPTH + 3;
   localparam int RUN_PLAIN    = 300;
   localparam int RUN_LEAKY    = 400;
   localparam int RUN_CLEAR    = 100;
   localparam int MAX_SYMBOLS  = RUN_PLAIN + RUN_LEAKY + RUN_CLEAR;
   // Symbols plus reset plus room for the APB transfers
   localparam int STIM_CYCLES  = RESET_CYCLES + MAX_SYMBOLS * SYM_PERIOD + 64;
   localparam int MAX_CYCLES   = 3 * STIM_CYCLES;
   localparam logic [ROT_W-1:0] POS_LEVEL = ROT_W'(400);
   localparam logic [ROT_W-1:0] NEG_LEVEL = ROT_W'(-400);

   logic             clk;
   logic             reset;
   logic             symEn;
   logic [ROT_W-1:0] zrRe [4];
   logic [ROT_W-1:0] prRe [4];
   logic [ROT_W-1:0] mrRe [4];
   logic [ROT_W-1:0] zrIm [4];
   logic [ROT_W-1:0] prIm [4];
   logic [ROT_W-1:0] mrIm [4];
   logic             pSel;
   logic             pEnable;
   logic             pWrite;
   logic [3:0]       pAddr;
   logic [31:0]      pWData;
   logic [31:0]      pRData;
   logic             pReady;
   logic             pSlvErr;
   stateIdx_t        index;
   logic             decision;
   logic [ROT_W-1:0] phaseError;

   // Path history, entry j+1 is the state after symbol j
   stateIdx_t        pathState [MAX_SYMBOLS+1];
   logic [ROT_W-1:0] pathImag [MAX_SYMBOLS];
   integer           seed;
   int               symNum;
   int               decFrom;
   int               phaseFrom;

   soqpskViterbi dut (
      .clk(clk), .reset(reset), .symEn(symEn),
      .mfZr0Real(zrRe[0]), .mfPr0Real(prRe[0]), .mfMr0Real(mrRe[0]),
      .mfZr1Real(zrRe[1]), .mfPr1Real(prRe[1]), .mfMr1Real(mrRe[1]),
      .mfZr2Real(zrRe[2]), .mfPr2Real(prRe[2]), .mfMr2Real(mrRe[2]),
      .mfZr3Real(zrRe[3]), .mfPr3Real(prRe[3]), .mfMr3Real(mrRe[3]),
      .mfZr0Imag(zrIm[0]), .mfPr0Imag(prIm[0]), .mfMr0Imag(mrIm[0]),
      .mfZr1Imag(zrIm[1]), .mfPr1Imag(prIm[1]), .mfMr1Imag(mrIm[1]),
      .mfZr2Imag(zrIm[2]), .mfPr2Imag(prIm[2]), .mfMr2Imag(mrIm[2]),
      .mfZr3Imag(zrIm[3]), .mfPr3Imag(prIm[3]), .mfMr3Imag(mrIm[3]),
      .pSel(pSel), .pEnable(pEnable), .pWrite(pWrite), .pAddr(pAddr), .pWData(pWData),
      .pRData(pRData), .pReady(pReady), .pSlvErr(pSlvErr),
      .index(index), .decision(decision), .phaseError(phaseError)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // --------------------
   // Reference: rotating branch when the path changed state
   function automatic logic expectedDecision(input int j);
      return pathState[j+1] != pathState[j];
   endfunction

   function automatic logic [ROT_W-1:0] expectedImag(input int j);
      return pathImag[j];
   endfunction

   // Best state is the path state after the symbol
   function automatic stateIdx_t expectedIndex(input int j);
      return pathState[j+1];
   endfunction

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
      if (got !== expected) begin
         $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, expected);
         $display("Result: FAILED");
         $fatal(1, "Value mismatch on %s", name);
      end
   endtask

   task automatic nextCycle();
      @(posedge clk);
      #1;
   endtask

   // --------------------
   task automatic writeApb(input logic [3:0] addr, input logic [31:0] data, output logic err);
      pSel    = 1'b1;
      pEnable = 1'b0;
      pWrite  = 1'b1;
      pAddr   = addr;
      pWData  = data;
      nextCycle();
      pEnable = 1'b1;
      @(negedge clk);
      checkValue("pReady", 32'(pReady), 32'd1);
      err = pSlvErr;
      nextCycle();
      pSel    = 1'b0;
      pEnable = 1'b0;
      pWrite  = 1'b0;
   endtask

   task automatic readApb(input logic [3:0] addr, output logic [31:0] data, output logic err);
      pSel    = 1'b1;
      pEnable = 1'b0;
      pWrite  = 1'b0;
      pAddr   = addr;
      nextCycle();
      pEnable = 1'b1;
      @(negedge clk);
      checkValue("pReady", 32'(pReady), 32'd1);
      data = pRData;
      err  = pSlvErr;
      nextCycle();
      pSel    = 1'b0;
      pEnable = 1'b0;
   endtask

   task automatic writeExpect(input logic [3:0] addr, input logic [31:0] data);
      logic err;
      writeApb(addr, data, err);
      checkValue("pSlvErr", 32'(err), 32'd0);
   endtask

   task automatic readExpect(input logic [3:0] addr, input logic [31:0] expected,
                             input string name);
      logic [31:0] data;
      logic        err;
      readApb(addr, data, err);
      checkValue("pSlvErr", 32'(err), 32'd0);
      checkValue(name, data, expected);
   endtask

   // --------------------
   // All real inputs low, imaginary parts zero
   task automatic clearInputs();
      for (int s = 0; s < 4; s++) begin
         zrRe[s] = NEG_LEVEL;
         prRe[s] = NEG_LEVEL;
         mrRe[s] = NEG_LEVEL;
         zrIm[s] = '0;
         prIm[s] = '0;
         mrIm[s] = '0;
      end
   endtask

   // One trellis step of the random path, inputs indexed by the predecessor
   task automatic driveSymbol();
      int               rnd;
      logic             even;
      logic             rotate;
      stateIdx_t        prev;
      logic [ROT_W-1:0] imag;
      rnd    = $random(seed);
      // Symbol 0 is an odd step, parity flips every symbol
      even   = symNum[0];
      rotate = rnd[0];
      imag   = rnd[ROT_W+1:2];
      prev   = pathState[symNum];
      clearInputs();
      if (!rotate) begin
         zrRe[prev] = POS_LEVEL;
         zrIm[prev] = imag;
      end else if (even) begin
         prRe[prev] = POS_LEVEL;
         prIm[prev] = imag;
      end else begin
         mrRe[prev] = POS_LEVEL;
         mrIm[prev] = imag;
      end
      pathState[symNum+1] = rotate ? partnerState(prev, even) : prev;
      pathImag[symNum]    = imag;
      symEn = 1'b1;
      nextCycle();
      symEn = 1'b0;
      repeat (SYM_PERIOD - 1) nextCycle();
      symNum++;
   endtask

   task automatic runSymbols(input int count);
      repeat (count) driveSymbol();
   endtask

   // --------------------
   // Compare outputs after each symEn with the stored path
   initial begin : compare
      int n;
      n = 0;
      forever begin
         @(posedge clk);
         if (symEn && !reset) begin
            @(negedge clk);
            if (n >= decFrom) begin
               checkValue("decision", 32'(decision), 32'(expectedDecision(n - LAT_DEC)));
            end
            // Best state and phase error share the same window
            if (n >= phaseFrom) begin
               checkValue("index", 32'(index), 32'(expectedIndex(n - LAT_IDX)));
               checkValue("phaseError", 32'(phaseError), 32'(expectedImag(n - LAT_PHASE)));
            end
            n++;
         end
      end
   end

   initial begin : watchdog
      int cycles;
      cycles = 0;
      forever begin
         @(posedge clk);
         cycles++;
         if (cycles > MAX_CYCLES) begin
            $display("Result: FAILED");
            $fatal(1, "Simulation did not finish within %0d cycles", MAX_CYCLES);
         end
      end
   end

   initial begin : stimulus
      logic [31:0] value;
      logic        err;
      logic [7:0]  newDecay;
      seed      = 67;
      symNum    = 0;
      decFrom   = LAT_DEC;
      phaseFrom = LAT_PHASE;
      clk       = 1'b0;
      reset     = 1'b1;
      symEn     = 1'b0;
      pSel      = 1'b0;
      pEnable   = 1'b0;
      pWrite    = 1'b0;
      pAddr     = '0;
      pWData    = '0;
      clearInputs();
      pathState[0] = 2'd0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      reset = 1'b0;

      // Reset values
      readExpect(`REG_DECAY, 32'd255, "DECAY");
      readExpect(`REG_SYMCOUNT, 32'd0, "SYMCOUNT");
      checkValue("decision", 32'(decision), 32'd0);
      checkValue("phaseError", 32'(phaseError), 32'd0);
      checkValue("index", 32'(index), 32'd0);

      // Register access and a bad offset
      value    = $random(seed);
      newDecay = value[7:0];
      writeExpect(`REG_DECAY, {24'd0, newDecay});
      readExpect(`REG_DECAY, {24'd0, newDecay}, "DECAY");
      writeApb(4'hC, 32'hFFFF_FFFF, err);
      checkValue("pSlvErr", 32'(err), 32'd1);
      readApb(4'hC, value, err);
      checkValue("pSlvErr", 32'(err), 32'd1);
      readExpect(`REG_DECAY, {24'd0, newDecay}, "DECAY");
      readExpect(`REG_SYMCOUNT, 32'd0, "SYMCOUNT");
      readExpect(`REG_CTRL, 32'd0, "CTRL");

      // Full decay, metrics reach the normalization point
      writeExpect(`REG_DECAY, 32'd255);
      runSymbols(RUN_PLAIN);
      // Bad offset with a nonzero count, no clear may fire
      writeApb(4'hC, 32'hFFFF_FFFF, err);
      checkValue("pSlvErr", 32'(err), 32'd1);
      readExpect(`REG_SYMCOUNT, 32'(RUN_PLAIN), "SYMCOUNT");

      // Leaky metrics over a long run
      writeExpect(`REG_DECAY, 32'd200);
      runSymbols(RUN_LEAKY);
      readExpect(`REG_SYMCOUNT, 32'(symNum), "SYMCOUNT");

      // Metric clear, decisions checked again after the full latency
      writeExpect(`REG_CTRL, 32'd1);
      readExpect(`REG_CTRL, 32'd0, "CTRL");
      readExpect(`REG_SYMCOUNT, 32'd0, "SYMCOUNT");
      decFrom   = symNum + LAT_DEC;
      phaseFrom = symNum + LAT_PHASE;
      runSymbols(RUN_CLEAR);
      readExpect(`REG_SYMCOUNT, 32'(RUN_CLEAR), "SYMCOUNT");

      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* build.f */
+incdir+.
soqpskPkg.sv
soqpskAcs.sv
maxMetric4.sv
traceBackSoqpsk.sv
viterbiRegs.sv
soqpskViterbi.sv
soqpskViterbi_checker.sv
soqpskViterbiTb.sv

/* Makefile */
# Verilator simulation of the SOQPSK trellis decoder testbench

VERILATOR ?= verilator
TOP       ?= soqpskViterbiTb
FILE_LIST ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# Exit status of the simulation is the pass or fail result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
